// File: flist.f
+incdir+logic
logic/cabinet_pkg.sv
logic/trackball_if.sv
logic/trackball_accum.sv
logic/cabinet_control.sv
logic/panel_mapper.sv
logic/cabinet_top.sv
tests/tb_clock.sv
tests/tb_cabinet.sv

// File: run.sh
#!/bin/sh
# Build and run the cabinet adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f flist.f \
	--top-module tb_cabinet \
	-Mdir obj_dir \
	-o sim_cabinet

# The simulator may exit non-zero on failure, the log decides
./obj_dir/sim_cabinet > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tests/tb_cabinet.sv
// Cabinet adapter testbench
// Table driven panel mapping checks plus reset sequencing, advance
// stretching, trackball sums, Sinistar latches and the audio mix

`timescale 1ns/10ps
`default_nettype none

module tb_cabinet;

	typedef struct packed {
		logic [6:0] game;
		logic [9:0] p1;
		logic [9:0] p2;
		logic [3:0] coins;
		logic [3:0] btn;
		logic [7:0] ja;
		logic [7:0] jb;
		logic [3:0] flags; // blitter_sc2, sinistar, speedball, portrait
	} row_t;

	localparam int STRETCH = 16;
	localparam int ROWS    = 13;

	// Players {f,e,d,c,b,a,up,down,left,right}, coins {coin1,coin2,start1,start2}
	localparam row_t MAP_ROWS [ROWS] = '{
		'{7'd0,   10'h008, 10'h001, 4'b1000, 4'b0010, 8'h7E, 8'h7E, 4'b0000},
		'{7'd2,   10'h022, 10'h000, 4'b0010, 4'b1000, 8'hDB, 8'hDB, 4'b1000},
		'{7'd1,   10'h011, 10'h002, 4'b0101, 4'b1010, 8'hF9, 8'hFE, 4'b0000},
		'{7'd3,   10'h004, 10'h009, 4'b0000, 4'b0000, 8'hFD, 8'hF6, 4'b0000},
		'{7'd4,   10'h112, 10'h048, 4'b0010, 4'b0100, 8'h6E, 8'hBB, 4'b0000},
		'{7'd5,   10'h028, 10'h014, 4'b0001, 4'b0100, 8'hDE, 8'hED, 4'b0000},
		'{7'd6,   10'h009, 10'h000, 4'b1000, 4'b0010, 8'h11, 8'h11, 4'b0101},
		'{7'd6,   10'h000, 10'h006, 4'b0000, 4'b0000, 8'h99, 8'h99, 4'b0101},
		'{7'd7,   10'h003, 10'h000, 4'b0111, 4'b0010, 8'hF0, 8'hF0, 4'b0001},
		'{7'd8,   10'h014, 10'h000, 4'b0000, 4'b1000, 8'hFD, 8'hFF, 4'b0000},
		'{7'd9,   10'h098, 10'h021, 4'b1010, 4'b0110, 8'h91, 8'h28, 4'b0010},
		'{7'd10,  10'h3FF, 10'h3FF, 4'b1111, 4'b1111, 8'hFF, 8'hFF, 4'b0000},
		'{7'd127, 10'h3FF, 10'h000, 4'b1111, 4'b1111, 8'hFF, 8'hFF, 4'b0000}
	};

	logic                 clk_sys;
	logic                 reset;
	logic                 status_reset;
	logic                 button_reset;
	logic                 rom_download;
	logic                 adv_request;
	logic                 auto_up;
	logic [6:0]           game;
	cabinet_pkg::player_t p1;
	cabinet_pkg::player_t p2;
	cabinet_pkg::coin_t   coins;
	logic                 mouse_strobe;
	logic                 mouse_idx;
	logic signed [8:0]    mouse_dx;
	logic signed [8:0]    mouse_dy;
	logic [7:0]           mouse_flags;
	logic [7:0]           audio;
	logic [15:0]          speech;
	logic                 game_reset;
	logic [3:0]           btn;
	logic [7:0]           ja;
	logic [7:0]           jb;
	logic [7:0]           an0;
	logic [7:0]           an1;
	logic [7:0]           an2;
	logic [7:0]           an3;
	logic [7:0]           sw;
	logic                 blitter_sc2;
	logic                 sinistar;
	logic                 speedball;
	logic                 portrait;
	logic [16:0]          audio_mix;

	int                      seed = 44;
	logic [31:0]             rnd;
	cabinet_pkg::track_pos_t x0; // Expected mouse sums
	cabinet_pkg::track_pos_t y0;
	cabinet_pkg::track_pos_t x1;
	cabinet_pkg::track_pos_t y1;
	logic [1:0]              mb0;
	logic [1:0]              mb1;

	tb_clock #(.PERIOD(100), .RESET_CYCLES(2)) u_clock (.clk_sys(clk_sys), .reset(reset));

	cabinet_top #(.STRETCH(STRETCH)) dut (.*);

	task automatic fail_run();
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_panel(input cabinet_pkg::panel_t want, input string what);
		cabinet_pkg::panel_t got;
		got = {btn, ja, jb, an0, an1, an2, an3};
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s, panel %h expected %h", $time, what, got, want);
			fail_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s is %b expected %b", $time, what, got, want);
			fail_run();
		end
	endtask

	task automatic check_mix(input logic [16:0] got, input logic [16:0] want, input string what);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s is %h expected %h", $time, what, got, want);
			fail_run();
		end
	endtask

	task automatic check_count(input int got, input int want, input string what);
		if (got != want) begin
			$display("CHECK FAILED at %0t: %s is %0d cycles expected %0d", $time, what, got, want);
			fail_run();
		end
	endtask

	// Stimulus and registered outputs both live 10 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic count_advance(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: advance switch did not reach %b in %0d cycles", level, limit);
				fail_run();
			end
		end while (sw[1] !== level);
	endtask

	task automatic sinistar_step(input cabinet_pkg::player_t a, input cabinet_pkg::player_t b,
			input logic [7:0] stick, input string what);
		cabinet_pkg::panel_t want;
		p1 = a;
		p2 = b;
		next_cycle();
		p1 = '0;
		p2 = '0;
		next_cycle(); // Latched direction only, no stick held
		want = '{btn: 4'h0, ja: stick, jb: stick, an0: 8'h80, an1: 8'h80, an2: 8'h80,
			an3: 8'h80};
		check_panel(want, what);
	endtask

	// Joust, Bubbles and idle rules for random patterns
	function automatic cabinet_pkg::panel_t expect_panel(input logic [6:0] g,
			input cabinet_pkg::player_t a, input cabinet_pkg::player_t b,
			input cabinet_pkg::coin_t c);
		cabinet_pkg::panel_t e;
		e = '{btn: 4'hF, ja: 8'hFF, jb: 8'hFF, an0: 8'h80, an1: 8'h80, an2: 8'h80, an3: 8'h80};
		if (g == 7'd1 || g == 7'd3)
			e.btn = {c.start2, c.start1, c.coin1 | c.coin2, 1'b0};
		if (g == 7'd1) begin
			e.ja = ~{5'b00000, a.fire_a, a.right, a.left};
			e.jb = ~{5'b00000, b.fire_a, b.right, b.left};
		end else if (g == 7'd3) begin
			e.ja = ~{4'b0000, a.right, a.left, a.down, a.up};
			e.jb = ~{4'b0000, b.right, b.left, b.down, b.up};
		end
		return e;
	endfunction

	// Half the position, offset to the middle of the analog range
	function automatic logic [7:0] to_analog(input cabinet_pkg::track_pos_t v);
		logic [9:0] half;
		half = v >>> 1;
		return half[7:0] + 8'h80;
	endfunction

	initial begin
		int                  n;
		int                  i;
		cabinet_pkg::panel_t want;
		logic [16:0]         mix;

		status_reset = 1'b0;
		button_reset = 1'b0;
		rom_download = 1'b0;
		adv_request  = 1'b0;
		auto_up      = 1'b0;
		game         = 7'd0;
		p1           = '0;
		p2           = '0;
		coins        = '0;
		mouse_strobe = 1'b0;
		mouse_idx    = 1'b0;
		mouse_dx     = '0;
		mouse_dy     = '0;
		mouse_flags  = 8'h00;
		audio        = 8'h00;
		speech       = 16'h0000;

		n = 0;
		while (reset !== 1'b0) begin
			@(posedge clk_sys);
			n++;
			if (n > 10) begin
				$display("Timeout: reset was never released");
				fail_run();
			end
		end
		#10;

		// Game stays in reset until a ROM download ends
		for (i = 0; i < 3; i++) begin
			next_cycle();
			check_bit(game_reset, 1'b1, "game_reset before download");
		end
		rom_download = 1'b1;
		for (i = 0; i < 3; i++) begin
			next_cycle();
			check_bit(game_reset, 1'b1, "game_reset during download");
		end
		rom_download = 1'b0;
		next_cycle();
		check_bit(game_reset, 1'b1, "game_reset one cycle after download");
		next_cycle();
		check_bit(game_reset, 1'b0, "game_reset two cycles after download");
		status_reset = 1'b1;
		next_cycle();
		check_bit(game_reset, 1'b1, "game_reset from status");
		status_reset = 1'b0;
		next_cycle();
		check_bit(game_reset, 1'b0, "game_reset after status");
		button_reset = 1'b1;
		next_cycle();
		check_bit(game_reset, 1'b1, "game_reset from button");
		button_reset = 1'b0;
		next_cycle();
		check_bit(game_reset, 1'b0, "game_reset after button");

		for (i = 0; i < ROWS; i++) begin
			game  = MAP_ROWS[i].game;
			p1    = MAP_ROWS[i].p1;
			p2    = MAP_ROWS[i].p2;
			coins = MAP_ROWS[i].coins;
			next_cycle(); // Sinistar latches follow the stick
			want = '{btn: MAP_ROWS[i].btn, ja: MAP_ROWS[i].ja, jb: MAP_ROWS[i].jb,
				an0: 8'h80, an1: 8'h80, an2: 8'h80, an3: 8'h80};
			check_panel(want, $sformatf("table row %0d", i));
			check_bit(blitter_sc2, MAP_ROWS[i].flags[3], "blitter_sc2");
			check_bit(sinistar, MAP_ROWS[i].flags[2], "sinistar");
			check_bit(speedball, MAP_ROWS[i].flags[1], "speedball");
			check_bit(portrait, MAP_ROWS[i].flags[0], "portrait");
		end

		for (i = 0; i < 24; i++) begin
			rnd   = $random(seed);
			p1    = rnd[9:0];
			p2    = rnd[19:10];
			coins = rnd[23:20];
			case (rnd[25:24])
				2'd0:    game = cabinet_pkg::GAME_JOUST;
				2'd1:    game = cabinet_pkg::GAME_BUBBLES;
				default: game = {1'b1, rnd[31:26]};
			endcase
			#20;
			check_panel(expect_panel(game, p1, p2, coins), $sformatf("random pattern %0d", i));
			next_cycle();
		end

		p1    = '0;
		p2    = '0;
		coins = '0;
		auto_up = 1'b1;
		next_cycle();
		check_bit(sw[0], 1'b1, "auto_up switch");
		auto_up = 1'b0;
		#20;
		check_bit(sw[0], 1'b0, "auto_up switch released");

		adv_request = 1'b1;
		count_advance(1'b1, 8, n);
		check_count(n, 2, "advance latency");
		count_advance(1'b0, 4 * STRETCH, n);
		check_count(n, STRETCH, "advance width");
		adv_request = 1'b0;
		next_cycle();
		adv_request = 1'b1;
		count_advance(1'b1, 8, n);
		check_count(n, 2, "advance latency second request");
		repeat (5) next_cycle();
		adv_request = 1'b0;
		next_cycle();
		adv_request = 1'b1; // Retrigger while closed
		count_advance(1'b0, 4 * STRETCH, n);
		check_count(n, STRETCH + 2, "advance width after retrigger");
		adv_request = 1'b0;

		game = cabinet_pkg::GAME_SPEEDBALL;
		x0   = '0;
		y0   = '0;
		x1   = '0;
		y1   = '0;
		mb0  = 2'b00;
		mb1  = 2'b00;
		for (i = 0; i < 12; i++) begin
			rnd          = $random(seed);
			mouse_idx    = rnd[0];
			mouse_dx     = rnd[9:1];
			mouse_dy     = rnd[18:10];
			mouse_flags  = rnd[26:19];
			p1           = {5'b00000, rnd[27], 4'b0000};
			p2           = {5'b00000, rnd[28], 4'b0000};
			mouse_strobe = 1'b1;
			if (mouse_idx) begin
				x1 += mouse_dx;
				y1 += mouse_dy;
				mb1 = mouse_flags[1:0];
			end else begin
				x0 += mouse_dx;
				y0 += mouse_dy;
				mb0 = mouse_flags[1:0];
			end
			next_cycle();
			mouse_strobe = 1'b0;
			want = '{btn: 4'h0, ja: {3'b000, p1.fire_a | mb0[0], 4'b0000},
				jb: {3'b000, p2.fire_a | mb1[0], 4'b0000},
				an0: to_analog(y0), an1: to_analog(x0), an2: to_analog(y1), an3: to_analog(x1)};
			check_panel(want, $sformatf("trackball packet %0d", i));
		end

		game = cabinet_pkg::GAME_SINISTAR;
		sinistar_step(10'h006, 10'h000, 8'h88, "Sinistar left and down");
		sinistar_step(10'h005, 10'h00A, 8'h00, "Sinistar right and up win");
		sinistar_step(10'h000, 10'h002, 8'h80, "Sinistar left from player 2");
		sinistar_step(10'h001, 10'h004, 8'h08, "Sinistar right and down");

		for (i = 0; i < 11; i++) begin
			rnd    = $random(seed);
			game   = i[6:0];
			audio  = rnd[7:0];
			speech = rnd[31:16];
			#20;
			mix = audio * 17'd257; // Byte in both halves
			if (i == 6 || i == 7)
				mix = mix + {1'b0, speech}; // Speech boards only
			check_mix(audio_mix, mix, $sformatf("audio mix for game %0d", i));
			next_cycle();
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock and reset
// Free running clock and a synchronous reset held for a few cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#10 reset = 1'b0; // Released with the other stimulus
	end

endmodule

`default_nettype wire

// File: logic/cabinet_top.sv
// Cabinet input adapter top
// Host controls, mouse packets and status in, game board panel
// ports, switches, feature flags and audio mix out

`timescale 1ns/10ps
`default_nettype none

`include "cabinet_macros.svh"

module cabinet_top #(
	parameter int STRETCH = `CAB_ADV_STRETCH
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              status_reset,
	input  logic              button_reset,
	input  logic              rom_download,
	input  logic              adv_request,
	input  logic              auto_up,
	input  logic [6:0]        game,
	input  logic [9:0]        p1,
	input  logic [9:0]        p2,
	input  logic [3:0]        coins,
	input  logic              mouse_strobe,
	input  logic              mouse_idx,
	input  logic signed [8:0] mouse_dx,
	input  logic signed [8:0] mouse_dy,
	input  logic [7:0]        mouse_flags,
	input  logic [7:0]        audio,
	input  logic [15:0]       speech,
	output logic              game_reset,
	output logic [3:0]        btn,
	output logic [7:0]        ja,
	output logic [7:0]        jb,
	output logic [7:0]        an0,
	output logic [7:0]        an1,
	output logic [7:0]        an2,
	output logic [7:0]        an3,
	output logic [7:0]        sw,
	output logic              blitter_sc2,
	output logic              sinistar,
	output logic              speedball,
	output logic              portrait,
	output logic [16:0]       audio_mix
);

	logic                advance;
	logic                sin_x;
	logic                sin_y;
	cabinet_pkg::panel_t panel;

	trackball_if track ();

	trackball_accum u_accum (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mouse_strobe(mouse_strobe),
		.mouse_idx   (mouse_idx),
		.mouse_dx    (mouse_dx),
		.mouse_dy    (mouse_dy),
		.mouse_flags (mouse_flags),
		.tb          (track.accum)
	);

	cabinet_control #(.STRETCH(STRETCH)) u_control (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.status_reset(status_reset),
		.button_reset(button_reset),
		.rom_download(rom_download),
		.adv_request (adv_request),
		.p1          (p1),
		.p2          (p2),
		.game_reset  (game_reset),
		.advance     (advance),
		.sin_x       (sin_x),
		.sin_y       (sin_y)
	);

	panel_mapper u_mapper (
		.game       (cabinet_pkg::game_t'(game)), // Out of range codes map to idle
		.p1         (p1),
		.p2         (p2),
		.coins      (coins),
		.game_reset (game_reset),
		.advance    (advance),
		.auto_up    (auto_up),
		.sin_x      (sin_x),
		.sin_y      (sin_y),
		.tb         (track.mapper),
		.audio      (audio),
		.speech     (speech),
		.panel      (panel),
		.sw         (sw),
		.blitter_sc2(blitter_sc2),
		.sinistar   (sinistar),
		.speedball  (speedball),
		.portrait   (portrait),
		.audio_mix  (audio_mix)
	);

	assign btn = panel.btn;
	assign ja  = panel.ja;
	assign jb  = panel.jb;
	assign an0 = panel.an0;
	assign an1 = panel.an1;
	assign an2 = panel.an2;
	assign an3 = panel.an3;

endmodule

`default_nettype wire

// File: logic/panel_mapper.sv
// Panel mapper
// Per game mapping of player, coin and trackball controls onto the
// board's panel ports, plus service switches, board feature flags
// and the audio and speech mix

`timescale 1ns/10ps
`default_nettype none

`include "cabinet_macros.svh"

module panel_mapper (
	input  cabinet_pkg::game_t   game,
	input  cabinet_pkg::player_t p1,
	input  cabinet_pkg::player_t p2,
	input  cabinet_pkg::coin_t   coins,
	input  logic                 game_reset,
	input  logic                 advance,
	input  logic                 auto_up,
	input  logic                 sin_x,
	input  logic                 sin_y,
	trackball_if.mapper          tb,
	input  logic [7:0]           audio,
	input  logic [15:0]          speech,
	output cabinet_pkg::panel_t  panel,
	output logic [7:0]           sw,
	output logic                 blitter_sc2,
	output logic                 sinistar,
	output logic                 speedball,
	output logic                 portrait,
	output logic [16:0]          audio_mix
);

	logic       speech_en;
	logic       coin;
	logic [7:0] twin_stick; // Move on p1 stick, fire on p2 stick
	logic       sin_h;
	logic       sin_v;

	assign coin = coins.coin1 | coins.coin2;
	assign sin_h = p1.right | p1.left | p2.right | p2.left;
	assign sin_v = p1.up | p1.down | p2.up | p2.down;
	assign twin_stick = {p1.fire_d | p2.right, p1.fire_c | p2.left, p1.fire_b | p2.down,
		p1.fire_a | p2.up, p1.right, p1.left, p1.down, p1.up};

	assign sw = {6'h00, advance, auto_up};

	always_comb begin
		panel       = '{btn: 4'hF, ja: 8'hFF, jb: 8'hFF, an0: 8'h80, an1: 8'h80,
			an2: 8'h80, an3: 8'h80};
		blitter_sc2 = 1'b0;
		sinistar    = 1'b0;
		speedball   = 1'b0;
		portrait    = 1'b0;
		speech_en   = 1'b0;

		if (game < `CAB_GAME_COUNT) begin
			panel.btn = {coins.start2, coins.start1, coin, game_reset};
			case (game)
				cabinet_pkg::GAME_ROBOTRON, cabinet_pkg::GAME_SPLAT: begin
					blitter_sc2 = (game == cabinet_pkg::GAME_SPLAT);
					panel.btn   = {coins.start1, coins.start2, coin, game_reset};
					panel.ja    = ~twin_stick;
					panel.jb    = ~twin_stick;
				end
				cabinet_pkg::GAME_JOUST: begin
					panel.ja = ~{5'b00000, p1.fire_a, p1.right, p1.left};
					panel.jb = ~{5'b00000, p2.fire_a, p2.right, p2.left};
				end
				cabinet_pkg::GAME_BUBBLES: begin
					panel.ja = ~{4'b0000, p1.right, p1.left, p1.down, p1.up};
					panel.jb = ~{4'b0000, p2.right, p2.left, p2.down, p2.up};
				end
				cabinet_pkg::GAME_STARGATE: begin // Thrust shared by left and right
					panel.ja = ~{p1.fire_e, p1.up, p1.down, p1.left | p1.right,
						p1.fire_d, p1.fire_c, p1.fire_b, p1.fire_a};
					panel.jb = ~{p2.fire_e, p2.up, p2.down, p2.left | p2.right,
						p2.fire_d, p2.fire_c, p2.fire_b, p2.fire_a};
				end
				cabinet_pkg::GAME_ALIENAR: begin
					panel.btn = {coins.start1, coins.start2, coin, game_reset};
					panel.ja  = ~{2'b00, p1.fire_b, p1.fire_a, p1.right, p1.left, p1.down, p1.up};
					panel.jb  = ~{2'b00, p2.fire_b, p2.fire_a, p2.right, p2.left, p2.down, p2.up};
				end
				cabinet_pkg::GAME_SINISTAR: begin
					sinistar  = 1'b1;
					speech_en = 1'b1;
					portrait  = 1'b1;
					panel.ja  = {sin_x, 2'b00, sin_h, sin_y, 2'b00, sin_v};
					panel.jb  = {sin_x, 2'b00, sin_h, sin_y, 2'b00, sin_v};
				end
				cabinet_pkg::GAME_PLAYBALL: begin
					speech_en = 1'b1;
					portrait  = 1'b1;
					panel.btn = {2'b00, coin, game_reset};
					panel.ja  = ~{4'b0000, coins.start2, p1.right, p1.left, coins.start1};
					panel.jb  = panel.ja;
				end
				cabinet_pkg::GAME_LOTTOFUN: begin
					panel.btn = {coins.start1 | p1.fire_a, 1'b0, coin, game_reset};
					panel.ja  = ~{4'b0000, p1.right, p1.left, p1.down, p1.up};
				end
				cabinet_pkg::GAME_SPEEDBALL: begin
					speedball = 1'b1;
					panel.ja  = {p1.fire_d, p1.fire_c, p1.fire_b, p1.fire_a | tb.btns0[0],
						p1.right, p1.left, p1.down, p1.up};
					panel.jb  = {p2.fire_d, p2.fire_c, p2.fire_b, p2.fire_a | tb.btns1[0],
						p2.right, p2.left, p2.down, p2.up};
					panel.an0 = {~tb.y0[8], tb.y0[7:1]};
					panel.an1 = {~tb.x0[8], tb.x0[7:1]};
					panel.an2 = {~tb.y1[8], tb.y1[7:1]};
					panel.an3 = {~tb.x1[8], tb.x1[7:1]};
				end
				default: ;
			endcase
		end
	end

	assign audio_mix = {1'b0, audio, audio} + (speech_en ? {1'b0, speech} : 17'd0);

endmodule

`default_nettype wire

// File: logic/cabinet_control.sv
// Cabinet control
// Holds the game in reset until a ROM image is loaded, stretches
// the advance request into a long service switch pulse and latches
// the last Sinistar stick directions

`timescale 1ns/10ps
`default_nettype none

`include "cabinet_macros.svh"

module cabinet_control #(
	parameter int STRETCH = `CAB_ADV_STRETCH
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 status_reset,
	input  logic                 button_reset,
	input  logic                 rom_download,
	input  logic                 adv_request,
	input  cabinet_pkg::player_t p1,
	input  cabinet_pkg::player_t p2,
	output logic                 game_reset,
	output logic                 advance,
	output logic                 sin_x,
	output logic                 sin_y
);

	localparam int CW = $clog2(STRETCH + 1);

	logic          download_d;
	logic          rom_loaded;
	logic          adv_d;
	logic          adv_edge;
	logic [CW-1:0] adv_count;

	assign adv_edge = adv_request & ~adv_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			game_reset <= 1'b1;
		end else begin
			download_d <= rom_download;
			if (download_d & ~rom_download)
				rom_loaded <= 1'b1; // End of download
			game_reset <= status_reset | button_reset | rom_download | ~rom_loaded;
		end
	end

	// Advance pulse, edge reloads the counter
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adv_d     <= 1'b0;
			adv_count <= '0;
			advance   <= 1'b0;
		end else begin
			adv_d <= adv_request;
			if (adv_edge)
				adv_count <= CW'(STRETCH);
			else if (adv_count != '0)
				adv_count <= adv_count - 1'b1;
			advance <= (adv_count != '0);
		end
	end

	// Right wins over left, up over down
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sin_x <= 1'b0;
			sin_y <= 1'b0;
		end else begin
			if (p1.right | p2.right)
				sin_x <= 1'b0;
			else if (p1.left | p2.left)
				sin_x <= 1'b1;

			if (p1.up | p2.up)
				sin_y <= 1'b0;
			else if (p1.down | p2.down)
				sin_y <= 1'b1;
		end
	end

	adv_from_edge: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(advance) |-> $past(adv_edge, 2)
	) else $error("advance rose without a request edge");

endmodule

`default_nettype wire

// File: logic/trackball_accum.sv
// Trackball accumulator
// Sums relative mouse motion into two 10 bit positions, one per
// mouse index, and keeps the last button state of each mouse

`timescale 1ns/10ps
`default_nettype none

module trackball_accum (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              mouse_strobe,
	input  logic              mouse_idx,
	input  logic signed [8:0] mouse_dx,
	input  logic signed [8:0] mouse_dy,
	input  logic [7:0]        mouse_flags,
	trackball_if.accum        tb
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tb.x0    <= '0;
			tb.y0    <= '0;
			tb.x1    <= '0;
			tb.y1    <= '0;
			tb.btns0 <= 2'b00;
			tb.btns1 <= 2'b00;
		end else if (mouse_strobe) begin
			// Deltas sign extend, sums wrap at 10 bits
			if (!mouse_idx) begin
				tb.x0    <= tb.x0 + mouse_dx;
				tb.y0    <= tb.y0 + mouse_dy;
				tb.btns0 <= mouse_flags[1:0];
			end else begin
				tb.x1    <= tb.x1 + mouse_dx;
				tb.y1    <= tb.y1 + mouse_dy;
				tb.btns1 <= mouse_flags[1:0];
			end
		end
	end

	// Host must give a valid index with every packet
	idx_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		mouse_strobe |-> !$isunknown(mouse_idx)
	) else $error("mouse_idx unknown during strobe");

endmodule

`default_nettype wire

// File: logic/trackball_if.sv
// Trackball bus
// Two accumulated mouse positions and their buttons

`timescale 1ns/10ps
`default_nettype none

interface trackball_if;

	cabinet_pkg::track_pos_t x0;
	cabinet_pkg::track_pos_t y0;
	cabinet_pkg::track_pos_t x1;
	cabinet_pkg::track_pos_t y1;
	logic [1:0]              btns0;
	logic [1:0]              btns1;

	modport accum (output x0, y0, x1, y1, btns0, btns1);

	modport mapper (input x0, y0, x1, y1, btns0, btns1);

endinterface

`default_nettype wire

// File: logic/cabinet_pkg.sv
// Cabinet adapter types
// Game select, player and coin controls, board panel words
// and trackball coordinates

`default_nettype none

`include "cabinet_macros.svh"

package cabinet_pkg;

	typedef enum logic [6:0] {
		GAME_ROBOTRON  = `CAB_GAME_ROBOTRON,
		GAME_JOUST     = `CAB_GAME_JOUST,
		GAME_SPLAT     = `CAB_GAME_SPLAT,
		GAME_BUBBLES   = `CAB_GAME_BUBBLES,
		GAME_STARGATE  = `CAB_GAME_STARGATE,
		GAME_ALIENAR   = `CAB_GAME_ALIENAR,
		GAME_SINISTAR  = `CAB_GAME_SINISTAR,
		GAME_PLAYBALL  = `CAB_GAME_PLAYBALL,
		GAME_LOTTOFUN  = `CAB_GAME_LOTTOFUN,
		GAME_SPEEDBALL = `CAB_GAME_SPEEDBALL
	} game_t;

	// One player, active high
	typedef struct packed {
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} coin_t;

	// Board side ports, btn/ja/jb mostly active low
	typedef struct packed {
		logic [3:0] btn;
		logic [7:0] ja;
		logic [7:0] jb;
		logic [7:0] an0;
		logic [7:0] an1;
		logic [7:0] an2;
		logic [7:0] an3;
	} panel_t;

	typedef logic signed [9:0] track_pos_t;

endpackage

`default_nettype wire

// File: logic/cabinet_macros.svh
// Cabinet input adapter constants
// Game select codes as sent by the host, advance stretch length
// and the number of supported games

`ifndef CABINET_MACROS_SVH
`define CABINET_MACROS_SVH

// About 87 ms at 12 MHz
`define CAB_ADV_STRETCH 1048575

`define CAB_GAME_COUNT 10

`define CAB_GAME_ROBOTRON  7'd0
`define CAB_GAME_JOUST     7'd1
`define CAB_GAME_SPLAT     7'd2
`define CAB_GAME_BUBBLES   7'd3
`define CAB_GAME_STARGATE  7'd4
`define CAB_GAME_ALIENAR   7'd5
`define CAB_GAME_SINISTAR  7'd6
`define CAB_GAME_PLAYBALL  7'd7
`define CAB_GAME_LOTTOFUN  7'd8
`define CAB_GAME_SPEEDBALL 7'd9

`endif
